/* capture/fletcher_checksum.sv */
`timescale 1ns/10ps
`default_nettype none

`include "img_capture_settings.svh"

module fletcher_checksum
    import img_capture_pkg::*;
(
    input  wire                 clk,
    input  wire                 reset,
    input  wire                 sum_clear,
    input  wire                 sum_en,
    input  wire word_beat_t     word,
    output logic [31:0]         checksum
);
    localparam logic [`IMG_WORD_WIDTH-1:0] MODULUS = '1;

    logic [`IMG_WORD_WIDTH-1:0] sum_a;
    logic [`IMG_WORD_WIDTH-1:0] sum_b;
    logic [`IMG_WORD_WIDTH-1:0] next_a;

    // Addition modulo 65535 for inputs below 65536
    function automatic logic [`IMG_WORD_WIDTH-1:0] mod_add(
        input logic [`IMG_WORD_WIDTH-1:0] x,
        input logic [`IMG_WORD_WIDTH-1:0] y
    );
        logic [`IMG_WORD_WIDTH:0] s;
        s = {1'b0, x} + {1'b0, y};
        if (s >= {1'b0, MODULUS}) begin
            s = s - {1'b0, MODULUS};
        end
        return s[`IMG_WORD_WIDTH-1:0];
    endfunction

    assign next_a   = mod_add(sum_a, word.data);
    assign checksum = {sum_b, sum_a};

    always_ff @(posedge clk) begin
        if (reset || sum_clear) begin
            sum_a <= '0;
            sum_b <= '0;
        end else if (sum_en) begin
            sum_a <= next_a;
            sum_b <= mod_add(sum_b, next_a);
        end
    end

    a_sums_reduced: assert property (@(posedge clk) disable iff (reset)
        (sum_a < MODULUS) && (sum_b < MODULUS));

endmodule

`default_nettype wire

/* capture/frame_sequencer.sv */
`timescale 1ns/10ps
`default_nettype none

`include "img_capture_settings.svh"

module frame_sequencer
    import img_capture_pkg::*;
(
    input  wire                                                 clk,
    input  wire                                                 reset,
    input  wire                                                 start,
    input  wire [`IMG_HEADER_WORDS-1:0][`IMG_WORD_WIDTH-1:0]    header,
    input  wire pixel_bus_t                                     pixel_q,
    input  wire [31:0]                                          checksum,
    output logic                                                busy,
    output logic                                                done,
    output logic                                                word_valid,
    output word_beat_t                                          word,
    output logic                                                sum_clear,
    output logic                                                sum_en,
    output logic                                                frame_active,
    output logic [`IMG_WORD_COUNT_WIDTH-1:0]                    word_count
);
    localparam int WW = `IMG_WORD_WIDTH;
    localparam int HW = $clog2(`IMG_HEADER_WORDS);

    typedef enum logic [2:0] {
        S_IDLE,
        S_HEADER,
        S_WAIT_LOW,
        S_WAIT_HIGH,
        S_PIXELS,
        S_SUM_HI,
        S_SUM_LO
    } state_t;

    state_t         state;
    logic [HW-1:0]  hdr_idx;
    logic           accept;

    assign accept       = (state == S_IDLE) && start;
    assign sum_clear    = accept;
    assign busy         = (state != S_IDLE);
    assign frame_active = (state == S_PIXELS);

    // Checksum words themselves stay out of the sums
    assign sum_en = word_valid && ((state == S_HEADER) || (state == S_PIXELS));

    // ==================================================================
    // Word source select
    // ==================================================================
    always_comb begin
        word_valid = 1'b0;
        word.data  = '0;
        case (state)
            S_HEADER: begin
                word_valid = 1'b1;
                word.data  = header[hdr_idx];
            end
            S_PIXELS: begin
                word_valid = pixel_q.line_valid;
                word.data  = WW'(pixel_q.data);
            end
            S_SUM_HI: begin
                word_valid = 1'b1;
                word.data  = checksum[31:16];
            end
            S_SUM_LO: begin
                word_valid = 1'b1;
                word.data  = checksum[15:0];
            end
            default: begin
                word_valid = 1'b0;
            end
        endcase
    end

    // ==================================================================
    // State machine and word counter
    // ==================================================================
    always_ff @(posedge clk) begin
        if (reset) begin
            state      <= S_IDLE;
            hdr_idx    <= '0;
            done       <= 1'b0;
            word_count <= '0;
        end else begin
            done <= 1'b0;
            // Dropped words are counted too
            if (accept) begin
                word_count <= '0;
            end else if (word_valid) begin
                word_count <= word_count + 1'b1;
            end
            case (state)
                S_IDLE: begin
                    if (start) begin
                        state <= S_HEADER;
                    end
                end
                S_HEADER: begin
                    // Index wraps back to zero for the next capture
                    hdr_idx <= hdr_idx + 1'b1;
                    if (hdr_idx == HW'(`IMG_HEADER_WORDS - 1)) begin
                        state <= S_WAIT_LOW;
                    end
                end
                S_WAIT_LOW: begin
                    if (!pixel_q.frame_valid) begin
                        state <= S_WAIT_HIGH;
                    end
                end
                S_WAIT_HIGH: begin
                    if (pixel_q.frame_valid) begin
                        state <= S_PIXELS;
                    end
                end
                S_PIXELS: begin
                    if (!pixel_q.frame_valid) begin
                        state <= S_SUM_HI;
                    end
                end
                S_SUM_HI: state <= S_SUM_LO;
                S_SUM_LO: begin
                    state <= S_IDLE;
                    done  <= 1'b1;
                end
                default: state <= S_IDLE;
            endcase
        end
    end

    a_no_push_when_waiting: assert property (@(posedge clk) disable iff (reset)
        (state inside {S_IDLE, S_WAIT_LOW, S_WAIT_HIGH}) |-> !word_valid);

endmodule

`default_nettype wire

/* capture/pixel_stats.sv */
`timescale 1ns/10ps
`default_nettype none

`include "img_capture_settings.svh"

module pixel_stats
    import img_capture_pkg::*;
(
    input  wire                                 clk,
    input  wire                                 reset,
    input  wire                                 start,
    input  wire pixel_bus_t                     pixel_q,
    input  wire                                 frame_active,
    output logic [`IMG_STAT_COUNT_WIDTH-1:0]    highlight_count,
    output logic [`IMG_STAT_COUNT_WIDTH-1:0]    shadow_count
);
    logic [`IMG_GRID_BITS-1:0]  pos_x;
    logic [`IMG_GRID_BITS-1:0]  pos_y;
    logic                       lv_prev;
    logic                       sample;
    logic [`IMG_STAT_BITS-1:0]  top_bits;

    // Every fourth pixel of every fourth line
    assign sample   = pixel_q.line_valid && (pos_x == '0) && (pos_y == '0) && frame_active;
    assign top_bits = pixel_q.data[`IMG_PIXEL_WIDTH-1 -: `IMG_STAT_BITS];

    // ==================================================================
    // Grid position from line and frame edges
    // ==================================================================
    always_ff @(posedge clk) begin
        if (reset) begin
            pos_x   <= '0;
            pos_y   <= '0;
            lv_prev <= 1'b0;
        end else begin
            lv_prev <= pixel_q.line_valid;
            pos_x   <= pixel_q.line_valid ? pos_x + 1'b1 : '0;
            if (!pixel_q.frame_valid) begin
                pos_y <= '0;
            end else if (lv_prev && !pixel_q.line_valid) begin
                pos_y <= pos_y + 1'b1;
            end
        end
    end

    // Highlight and shadow counters
    always_ff @(posedge clk) begin
        if (reset || start) begin
            highlight_count <= '0;
            shadow_count    <= '0;
        end else if (sample) begin
            if (&top_bits) begin
                highlight_count <= highlight_count + 1'b1;
            end
            if (~|top_bits) begin
                shadow_count <= shadow_count + 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

/* capture/word_fifo.sv */
`timescale 1ns/10ps
`default_nettype none

`include "img_capture_settings.svh"

module word_fifo
    import img_capture_pkg::*;
(
    input  wire                 clk,
    input  wire                 reset,
    input  wire                 word_valid,
    input  wire word_beat_t     word,
    output logic                overflow_pulse,
    output logic                out_valid,
    input  wire                 out_ready,
    output word_beat_t          out_data
);
    localparam int DEPTH = `IMG_FIFO_DEPTH;
    localparam int AW    = $clog2(DEPTH);

    word_beat_t     mem [DEPTH];
    logic [AW-1:0]  wptr;
    logic [AW-1:0]  rptr;
    logic [AW:0]    fill;
    logic           full;
    logic           push;
    logic           pop;

    assign full           = (fill == (AW+1)'(DEPTH));
    assign push           = word_valid && !full;
    assign pop            = out_valid && out_ready;
    // Source cannot stall, so a push into a full buffer is lost
    assign overflow_pulse = word_valid && full;

    assign out_valid = (fill != '0);
    assign out_data  = mem[rptr];

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wptr] <= word;
        end
    end

    // ==================================================================
    // Pointers and fill level
    // ==================================================================
    always_ff @(posedge clk) begin
        if (reset) begin
            wptr <= '0;
            rptr <= '0;
            fill <= '0;
        end else begin
            if (push) begin
                wptr <= wptr + 1'b1;
            end
            if (pop) begin
                rptr <= rptr + 1'b1;
            end
            case ({push, pop})
                2'b10:   fill <= fill + 1'b1;
                2'b01:   fill <= fill - 1'b1;
                default: fill <= fill;
            endcase
        end
    end

    a_hold_while_stalled: assert property (@(posedge clk) disable iff (reset)
        (out_valid && !out_ready) |=> (out_valid && $stable(out_data)));

endmodule

`default_nettype wire

/* common/img_capture_pkg.sv */
`default_nettype none

`include "img_capture_settings.svh"

package img_capture_pkg;

    // Parallel camera port
    typedef struct packed {
        logic                           frame_valid;
        logic                           line_valid;
        logic [`IMG_PIXEL_WIDTH-1:0]    data;
    } pixel_bus_t;

    // Configuration request from software
    typedef struct packed {
        logic                           we;
        logic [`IMG_CFG_ADDR_WIDTH-1:0] addr;
        logic [`IMG_WORD_WIDTH-1:0]     wdata;
    } cfg_req_t;

    // Payload of every valid/ready stream
    typedef struct packed {
        logic [`IMG_WORD_WIDTH-1:0]     data;
    } word_beat_t;

    // Capture statistics read back by software
    typedef struct packed {
        logic [`IMG_WORD_COUNT_WIDTH-1:0]   words;
        logic [`IMG_STAT_COUNT_WIDTH-1:0]   highlight;
        logic [`IMG_STAT_COUNT_WIDTH-1:0]   shadow;
    } capture_counts_t;

endpackage

`default_nettype wire

/* common/img_capture_settings.svh */
`ifndef IMG_CAPTURE_SETTINGS_SVH
`define IMG_CAPTURE_SETTINGS_SVH

// ======================================================================
// Widths and counts
// ======================================================================
`define IMG_HEADER_WORDS        8
`define IMG_PIXEL_WIDTH         12
`define IMG_WORD_WIDTH          16
`define IMG_STAT_BITS           7
`define IMG_GRID_BITS           2
`define IMG_WORD_COUNT_WIDTH    18
`define IMG_STAT_COUNT_WIDTH    18
`define IMG_FIFO_DEPTH          16
`define IMG_CFG_ADDR_WIDTH      4

// ======================================================================
// Register map
// ======================================================================
// Header occupies eight words from this base
`define IMG_REG_HEADER          4'd0
`define IMG_REG_CONTROL         4'd8
`define IMG_REG_FLAGS           4'd9
`define IMG_REG_WORDS_LO        4'd10
`define IMG_REG_WORDS_HI        4'd11
`define IMG_REG_HIGHLIGHT_LO    4'd12
`define IMG_REG_HIGHLIGHT_HI    4'd13
`define IMG_REG_SHADOW_LO       4'd14
`define IMG_REG_SHADOW_HI       4'd15

`endif

/* dv/tb_img_capture.sv */
`timescale 1ns/10ps
`default_nettype none

`include "img_capture_settings.svh"

module tb_img_capture
    import img_capture_pkg::*;
();
    localparam int H_BLANK = 4;
    localparam int V_FRONT = 2;
    localparam int WAIT_LIMIT = 4000;

    logic                           clk;
    logic                           reset;
    pixel_bus_t                     pixel;
    cfg_req_t                       cfg;
    logic [`IMG_WORD_WIDTH-1:0]     cfg_rdata;
    logic                           out_valid;
    logic                           out_ready;
    word_beat_t                     out_data;

    // 0 ready held high, 1 random ready, 2 ready held low
    int                             ready_mode;
    logic [15:0]                    exp_q[$];
    logic [15:0]                    rx_q[$];
    logic [11:0]                    pix_q[$];

    img_capture_top dut (
        .clk(clk), .reset(reset), .pixel(pixel), .cfg(cfg), .cfg_rdata(cfg_rdata),
        .out_valid(out_valid), .out_ready(out_ready), .out_data(out_data)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    always @(posedge clk) begin
        #2;
        case (ready_mode)
            1:       out_ready = ($urandom % 4) != 0;
            2:       out_ready = 1'b0;
            default: out_ready = 1'b1;
        endcase
    end

    // Stream monitor
    always @(posedge clk) begin
        if (!reset && out_valid && out_ready) begin
            rx_q.push_back(out_data.data);
        end
    end

    // ======================================================================
    // Helpers
    // ======================================================================
    task automatic stop_with_failure(input string reason);
        $display("%s", reason);
        $display("TEST FAIL");
        $fatal(1);
    endtask

    task automatic check_equal(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected) begin
            $display("error at %0t: %s is %0h, expected %0h", $time, name, actual, expected);
            stop_with_failure("value mismatch");
        end
    endtask

    task automatic idle(input int cycles);
        repeat (cycles) @(posedge clk);
    endtask

    task automatic write_reg(input logic [`IMG_CFG_ADDR_WIDTH-1:0] addr, input logic [15:0] data);
        @(posedge clk);
        #2;
        cfg.we    = 1'b1;
        cfg.addr  = addr;
        cfg.wdata = data;
        @(posedge clk);
        #2;
        cfg.we = 1'b0;
    endtask

    task automatic read_reg(input logic [`IMG_CFG_ADDR_WIDTH-1:0] addr, output logic [15:0] data);
        @(posedge clk);
        #2;
        cfg.we   = 1'b0;
        cfg.addr = addr;
        #1;
        data = cfg_rdata;
    endtask

    task automatic wait_for_done();
        int n;
        logic [15:0] flags;
        n = 0;
        flags = '0;
        while (!flags[1]) begin
            if (n == WAIT_LIMIT) begin
                stop_with_failure("timed out waiting for the done flag");
            end
            read_reg(`IMG_REG_FLAGS, flags);
            n++;
        end
    endtask

    task automatic wait_for_words(input int count);
        int n;
        n = 0;
        while (rx_q.size() < count) begin
            if (n == WAIT_LIMIT) begin
                stop_with_failure("timed out waiting for stream words");
            end
            @(posedge clk);
            n++;
        end
    endtask

    // Fletcher-32 over the expected words so far with both sums mod 65535
    function automatic logic [31:0] fletcher_of_expected();
        int a;
        int b;
        a = 0;
        b = 0;
        foreach (exp_q[i]) begin
            a = (a + exp_q[i]) % 65535;
            b = (b + a) % 65535;
        end
        return {b[15:0], a[15:0]};
    endfunction

    // Mostly values right at or near the highlight and shadow limits
    function automatic logic [11:0] extreme_pixel();
        case ($urandom % 5)
            0:       return 12'hfff;
            1:       return 12'h000;
            2:       return {7'h7f, 5'($urandom)};
            3:       return {7'h00, 5'($urandom)};
            default: return 12'($urandom);
        endcase
    endfunction

    // Grid values just inside and just outside the top-7-bit limits
    function automatic logic [11:0] grid_pixel(input int n);
        case (n % 6)
            0:       return 12'hfe0;
            1:       return 12'h01f;
            2:       return 12'hfc0;
            3:       return 12'h020;
            4:       return 12'hfff;
            default: return 12'h000;
        endcase
    endfunction

    task automatic drive_frame(input int lines, input int width);
        int k;
        k = 0;
        for (int i = 0; i < V_FRONT; i++) begin
            @(posedge clk);
            #2;
            pixel.frame_valid = 1'b1;
            pixel.line_valid  = 1'b0;
        end
        for (int l = 0; l < lines; l++) begin
            for (int p = 0; p < width; p++) begin
                @(posedge clk);
                #2;
                pixel.line_valid = 1'b1;
                pixel.data       = pix_q[k];
                k++;
            end
            repeat (H_BLANK) begin
                @(posedge clk);
                #2;
                pixel.line_valid = 1'b0;
                pixel.data       = '0;
            end
        end
        @(posedge clk);
        #2;
        pixel.frame_valid = 1'b0;
    endtask

    // ======================================================================
    // One capture with prediction and checks
    // ======================================================================
    task automatic run_capture(input int lines, input int width, input int mode,
                               input bit extremes, input bit extra_starts);
        int n_exp;
        int hl;
        int sh;
        logic [11:0] v;
        logic [`IMG_STAT_BITS-1:0] top;
        logic [15:0] hdr;
        logic [15:0] lo;
        logic [15:0] hi;
        logic [15:0] flags;
        logic [31:0] sum;
        rx_q.delete();
        exp_q.delete();
        pix_q.delete();
        hl = 0;
        sh = 0;
        ready_mode = mode;
        for (int i = 0; i < `IMG_HEADER_WORDS; i++) begin
            hdr = 16'($urandom);
            write_reg(`IMG_REG_HEADER + i, hdr);
            exp_q.push_back(hdr);
        end
        for (int l = 0; l < lines; l++) begin
            for (int p = 0; p < width; p++) begin
                if (extremes && (l % 4 == 0) && (p % 4 == 0)) begin
                    v = grid_pixel((l / 4) * 3 + p / 4);
                end else begin
                    v = extremes ? extreme_pixel() : 12'($urandom);
                end
                pix_q.push_back(v);
                exp_q.push_back({4'h0, v});
                top = v[`IMG_PIXEL_WIDTH-1 -: `IMG_STAT_BITS];
                if ((l % 4 == 0) && (p % 4 == 0)) begin
                    if (&top) hl++;
                    if (top == '0) sh++;
                end
            end
        end
        sum = fletcher_of_expected();
        exp_q.push_back(sum[31:16]);
        exp_q.push_back(sum[15:0]);

        // Clear old flags and start in one write
        write_reg(`IMG_REG_CONTROL, 16'h3);
        if (extra_starts) write_reg(`IMG_REG_CONTROL, 16'h1);
        idle(10);
        if (extra_starts) write_reg(`IMG_REG_CONTROL, 16'h1);
        idle(10);
        drive_frame(lines, width);
        wait_for_done();
        read_reg(`IMG_REG_FLAGS, flags);
        check_equal("flags", flags, (mode == 2) ? 16'h6 : 16'h2);

        if (mode == 2) begin
            // Only the first FIFO-full of words survives
            n_exp = `IMG_FIFO_DEPTH;
            ready_mode = 0;
        end else begin
            n_exp = exp_q.size();
        end
        wait_for_words(n_exp);
        idle(8);
        check_equal("received words", rx_q.size(), n_exp);
        check_equal("out_valid", out_valid, 1'b0);
        for (int k = 0; k < n_exp; k++) begin
            check_equal($sformatf("out_data[%0d]", k), rx_q[k], exp_q[k]);
        end

        read_reg(`IMG_REG_WORDS_LO, lo);
        read_reg(`IMG_REG_WORDS_HI, hi);
        check_equal("word_count", {hi[1:0], lo}, exp_q.size());
        read_reg(`IMG_REG_HIGHLIGHT_LO, lo);
        read_reg(`IMG_REG_HIGHLIGHT_HI, hi);
        check_equal("highlight_count", {hi[1:0], lo}, hl);
        read_reg(`IMG_REG_SHADOW_LO, lo);
        read_reg(`IMG_REG_SHADOW_HI, hi);
        check_equal("shadow_count", {hi[1:0], lo}, sh);
        read_reg(`IMG_REG_FLAGS, flags);
        check_equal("busy after capture", flags[0], 1'b0);
    endtask

    // ======================================================================
    // Tests
    // ======================================================================
    task automatic reset_values_test();
        logic [15:0] rd;
        check_equal("out_valid", out_valid, 1'b0);
        for (int a = `IMG_REG_FLAGS; a <= `IMG_REG_SHADOW_HI; a++) begin
            read_reg(a, rd);
            check_equal($sformatf("reg[%0d]", a), rd, 16'h0);
        end
    endtask

    task automatic stream_order_test();
        run_capture(6, 8, 0, 1'b0, 1'b0);
    endtask

    task automatic grid_stats_test();
        run_capture(8, 12, 0, 1'b1, 1'b0);
    endtask

    task automatic random_ready_test();
        run_capture(4, 8, 1, 1'b0, 1'b0);
    endtask

    task automatic overflow_test();
        logic [15:0] flags;
        run_capture(4, 16, 2, 1'b0, 1'b0);
        write_reg(`IMG_REG_CONTROL, 16'h2);
        read_reg(`IMG_REG_FLAGS, flags);
        check_equal("flags after clear", flags, 16'h0);
    endtask

    task automatic start_while_busy_test();
        run_capture(3, 8, 0, 1'b0, 1'b1);
    endtask

    initial begin
        void'($urandom(32'hf0ce));
        reset      = 1'b1;
        pixel      = '0;
        cfg        = '0;
        out_ready  = 1'b0;
        ready_mode = 0;
        repeat (8) @(posedge clk);
        #2;
        reset = 1'b0;

        reset_values_test();
        stream_order_test();
        grid_stats_test();
        random_ready_test();
        overflow_test();
        start_while_busy_test();

        $display("TEST PASS");
        $finish;
    end

endmodule

`default_nettype wire

/* src/capture_regs.sv */
`timescale 1ns/10ps
`default_nettype none

`include "img_capture_settings.svh"

module capture_regs
    import img_capture_pkg::*;
(
    input  wire                                                 clk,
    input  wire                                                 reset,
    input  wire cfg_req_t                                       cfg,
    output logic [`IMG_WORD_WIDTH-1:0]                          cfg_rdata,
    output logic                                                start,
    output logic                                                clear,
    output logic [`IMG_HEADER_WORDS-1:0][`IMG_WORD_WIDTH-1:0]   header,
    input  wire                                                 busy,
    input  wire                                                 done,
    input  wire                                                 overflow_pulse,
    input  wire capture_counts_t                                counts
);
    localparam int WW = `IMG_WORD_WIDTH;
    localparam int HW = $clog2(`IMG_HEADER_WORDS);

    logic           in_header;
    logic [HW-1:0]  hdr_sel;
    logic           ctrl_write;
    logic           done_flag;
    logic           overflow_flag;

    assign in_header  = (cfg.addr < `IMG_REG_HEADER + `IMG_HEADER_WORDS);
    assign hdr_sel    = HW'(cfg.addr - `IMG_REG_HEADER);
    assign ctrl_write = cfg.we && (cfg.addr == `IMG_REG_CONTROL);

    // Header words written by software
    always_ff @(posedge clk) begin
        if (cfg.we && in_header) begin
            header[hdr_sel] <= cfg.wdata;
        end
    end

    // ==================================================================
    // Command pulses and sticky flags
    // ==================================================================
    always_ff @(posedge clk) begin
        if (reset) begin
            start         <= 1'b0;
            clear         <= 1'b0;
            done_flag     <= 1'b0;
            overflow_flag <= 1'b0;
        end else begin
            start <= ctrl_write && cfg.wdata[0];
            clear <= ctrl_write && cfg.wdata[1];
            // A new event wins over a clear on the same cycle
            if (done) begin
                done_flag <= 1'b1;
            end else if (clear) begin
                done_flag <= 1'b0;
            end
            if (overflow_pulse) begin
                overflow_flag <= 1'b1;
            end else if (clear) begin
                overflow_flag <= 1'b0;
            end
        end
    end

    // Read mux with the control register reading back as zero
    always_comb begin
        cfg_rdata = '0;
        if (!cfg.we) begin
            if (in_header) begin
                cfg_rdata = header[hdr_sel];
            end else begin
                case (cfg.addr)
                    `IMG_REG_FLAGS:        cfg_rdata = WW'({overflow_flag, done_flag, busy});
                    `IMG_REG_WORDS_LO:     cfg_rdata = counts.words[WW-1:0];
                    `IMG_REG_WORDS_HI:     cfg_rdata = WW'(counts.words >> WW);
                    `IMG_REG_HIGHLIGHT_LO: cfg_rdata = counts.highlight[WW-1:0];
                    `IMG_REG_HIGHLIGHT_HI: cfg_rdata = WW'(counts.highlight >> WW);
                    `IMG_REG_SHADOW_LO:    cfg_rdata = counts.shadow[WW-1:0];
                    `IMG_REG_SHADOW_HI:    cfg_rdata = WW'(counts.shadow >> WW);
                    default:               cfg_rdata = '0;
                endcase
            end
        end
    end

    // Commands only ever follow a control write
    a_cmd_from_write: assert property (@(posedge clk) disable iff (reset)
        (start || clear) |-> $past(cfg.we && (cfg.addr == `IMG_REG_CONTROL)));

endmodule

`default_nettype wire

/* src/img_capture_top.sv */
`timescale 1ns/10ps
`default_nettype none

`include "img_capture_settings.svh"

module img_capture_top
    import img_capture_pkg::*;
(
    input  wire                         clk,
    input  wire                         reset,
    input  wire pixel_bus_t             pixel,
    input  wire cfg_req_t               cfg,
    output logic [`IMG_WORD_WIDTH-1:0]  cfg_rdata,
    output logic                        out_valid,
    input  wire                         out_ready,
    output word_beat_t                  out_data
);
    pixel_bus_t                                         pixel_q;
    logic                                               start;
    logic                                               clear;
    logic [`IMG_HEADER_WORDS-1:0][`IMG_WORD_WIDTH-1:0]  header;
    logic                                               busy;
    logic                                               done;
    logic                                               word_valid;
    word_beat_t                                         word;
    logic                                               sum_clear;
    logic                                               sum_en;
    logic                                               frame_active;
    logic [31:0]                                        checksum;
    logic [`IMG_WORD_COUNT_WIDTH-1:0]                   word_count;
    logic [`IMG_STAT_COUNT_WIDTH-1:0]                   highlight_count;
    logic [`IMG_STAT_COUNT_WIDTH-1:0]                   shadow_count;
    logic                                               overflow_pulse;
    capture_counts_t                                    counts;

    // Single input stage; everything downstream sees pixel_q
    always_ff @(posedge clk) begin
        if (reset) begin
            pixel_q <= '0;
        end else begin
            pixel_q <= pixel;
        end
    end

    assign counts = '{words: word_count, highlight: highlight_count, shadow: shadow_count};

    capture_regs u_regs (
        .clk(clk), .reset(reset), .cfg(cfg), .cfg_rdata(cfg_rdata),
        .start(start), .clear(clear), .header(header), .busy(busy), .done(done),
        .overflow_pulse(overflow_pulse), .counts(counts)
    );

    frame_sequencer u_seq (
        .clk(clk), .reset(reset), .start(start), .header(header), .pixel_q(pixel_q),
        .checksum(checksum), .busy(busy), .done(done), .word_valid(word_valid),
        .word(word), .sum_clear(sum_clear), .sum_en(sum_en),
        .frame_active(frame_active), .word_count(word_count)
    );

    fletcher_checksum u_sum (
        .clk(clk), .reset(reset), .sum_clear(sum_clear), .sum_en(sum_en),
        .word(word), .checksum(checksum)
    );

    pixel_stats u_stats (
        .clk(clk), .reset(reset), .start(start), .pixel_q(pixel_q),
        .frame_active(frame_active), .highlight_count(highlight_count),
        .shadow_count(shadow_count)
    );

    word_fifo u_fifo (
        .clk(clk), .reset(reset), .word_valid(word_valid), .word(word),
        .overflow_pulse(overflow_pulse), .out_valid(out_valid),
        .out_ready(out_ready), .out_data(out_data)
    );

endmodule

`default_nettype wire

/* verilog.f */
+incdir+common
common/img_capture_pkg.sv
capture/fletcher_checksum.sv
capture/pixel_stats.sv
capture/word_fifo.sv
capture/frame_sequencer.sv
src/capture_regs.sv
src/img_capture_top.sv
dv/tb_img_capture.sv
